// File: src/masked_alu_pkg.sv
// --------------------
// Widths, op codes and bundles for the two-share masked ALU
// A value is always carried as s0 ^ s1
// The data width is fixed here and nowhere else
// --------------------

package masked_alu_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int XLEN    = 32;                 // Bits per share
  localparam int SHAMT_W = 5;                  // Shift amount width

  // --------------------
  // Operation codes
  // --------------------
  typedef enum logic [3:0] {
    OP_NOT    = 4'd0,                          // Masked bitwise not
    OP_XOR    = 4'd1,                          // Masked xor with refresh
    OP_AND    = 4'd2,                          // DOM and
    OP_IOR    = 4'd3,                          // DOM and on inverted share 0
    OP_SRLI   = 4'd4,                          // Shift right logical
    OP_SLLI   = 4'd5,                          // Shift left logical
    OP_RORI   = 4'd6,                          // Rotate right
    OP_MASK   = 4'd7,                          // Mask a plain value
    OP_REMASK = 4'd8                           // Refresh both shares
  } alu_op_e;

  // --------------------
  // Bundles
  // --------------------
  typedef struct packed {
    logic [XLEN-1:0] s0;                       // Share 0
    logic [XLEN-1:0] s1;                       // Share 1
  } share_pair_t;

  typedef struct packed {
    alu_op_e     op;
    share_pair_t rs1;
    share_pair_t rs2;                          // rs2.s0 low bits double as shamt
  } alu_req_t;

  // Fresh randomness, one word per use so no mask is reused across units
  typedef struct packed {
    logic [XLEN-1:0] z_and;                    // DOM cross-term refresh
    logic [XLEN-1:0] z_xor;                    // Xor output refresh
    logic [XLEN-1:0] z_pad;                    // Shift fill bits
    logic [XLEN-1:0] z_mask;                   // New mask word
  } rand_t;

endpackage

// File: src/masked_logic.sv
// --------------------
// Masked NOT, XOR, AND and OR, purely combinational
// The AND/OR outputs are only secure once registered, the
// DOM register stage lives in result_stage
// --------------------

module masked_logic
  import masked_alu_pkg::*;
(
  input  share_pair_t     i_a,                 // Operand a shares
  input  share_pair_t     i_b,                 // Operand b shares
  input  logic [XLEN-1:0] i_z_and,             // Refresh for the cross terms
  input  logic [XLEN-1:0] i_z_xor,             // Refresh for xor

  output share_pair_t     o_not,
  output share_pair_t     o_xor,
  output share_pair_t     o_and,
  output share_pair_t     o_ior
);

  // --------------------
  // DOM and gadget
  // --------------------

  // Inner terms stay in their own domain, the cross term is refreshed
  // with z before it is folded into the other domain's product
  function automatic share_pair_t dom_and(
    input logic [XLEN-1:0] a0,
    input logic [XLEN-1:0] a1,
    input logic [XLEN-1:0] b0,
    input logic [XLEN-1:0] b1,
    input logic [XLEN-1:0] z
  );
    logic [XLEN-1:0] inner0;
    logic [XLEN-1:0] inner1;
    logic [XLEN-1:0] cross0;
    logic [XLEN-1:0] cross1;
    share_pair_t     r;
    inner0 = a0 & b0;                          // Domain 0 product
    inner1 = a1 & b1;                          // Domain 1 product
    cross0 = (a0 & b1) ^ z;                    // Refreshed before joining
    cross1 = (a1 & b0) ^ z;
    r.s0   = inner0 ^ cross0;
    r.s1   = inner1 ^ cross1;
    return r;
  endfunction

  // --------------------
  // Not and xor
  // --------------------

  // Inverting one share inverts the value
  assign o_not.s0 = ~i_a.s0;
  assign o_not.s1 = i_a.s1;

  // Same z on both shares cancels on unmask but breaks the link
  // between the output shares and the input shares
  assign o_xor.s0 = i_a.s0 ^ i_b.s0 ^ i_z_xor;
  assign o_xor.s1 = i_a.s1 ^ i_b.s1 ^ i_z_xor;

  // --------------------
  // And and or
  // --------------------

  assign o_and = dom_and(i_a.s0, i_a.s1, i_b.s0, i_b.s1, i_z_and);

  // De Morgan, a | b = ~(~a & ~b)
  // Inverting share 0 of each operand inverts that operand
  share_pair_t nor_sh;                         // Shares of ~a & ~b

  assign nor_sh = dom_and(~i_a.s0, i_a.s1, ~i_b.s0, i_b.s1, i_z_and);

  assign o_ior.s0 = ~nor_sh.s0;                // Flip back to get the or
  assign o_ior.s1 = nor_sh.s1;

endmodule

// File: src/masked_shift.sv
// --------------------
// Per-share shift and rotate with random fill
// Both shares get the same fill bits so they cancel on unmask
// Non-shift ops see a rotate by zero
// --------------------

module masked_shift
  import masked_alu_pkg::*;
(
  input  alu_op_e            i_op,
  input  logic [SHAMT_W-1:0] i_shamt,          // From rs2.s0
  input  share_pair_t        i_a,              // rs1 shares
  input  logic [XLEN-1:0]    i_pad,            // Fill word

  output share_pair_t        o_shr
);

  logic               is_srl;
  logic               is_sll;
  logic               is_shift;
  logic [SHAMT_W-1:0] shamt;                   // Zero unless a shift op

  assign is_srl   = (i_op == OP_SRLI);
  assign is_sll   = (i_op == OP_SLLI);
  assign is_shift = is_srl | is_sll | (i_op == OP_RORI);
  assign shamt    = is_shift ? i_shamt : '0;

  // One share through the shifter, vacated bits taken from pad
  function automatic logic [XLEN-1:0] shift_share(
    input logic [XLEN-1:0]    s,
    input logic [SHAMT_W-1:0] sh,
    input logic               srl,
    input logic               sll,
    input logic [XLEN-1:0]    pad
  );
    logic [2*XLEN-1:0] dbl;
    logic [XLEN-1:0]   r;
    dbl = {s, s} >> sh;                        // Low half is the rotate
    if (srl) begin
      r = (s >> sh) | (pad & ~({XLEN{1'b1}} >> sh));   // Fill top bits
    end else if (sll) begin
      r = (s << sh) | (pad & ~({XLEN{1'b1}} << sh));   // Fill low bits
    end else begin
      r = dbl[XLEN-1:0];
    end
    return r;
  endfunction

  assign o_shr.s0 = shift_share(i_a.s0, shamt, is_srl, is_sll, i_pad);
  assign o_shr.s1 = shift_share(i_a.s1, shamt, is_srl, is_sll, i_pad);

endmodule

// File: src/result_stage.sv
// --------------------
// Result select and the single share register
// The share register is also the DOM register for AND/OR
// Flush in the issue cycle drops the op, no back-pressure
// --------------------

module result_stage
  import masked_alu_pkg::*;
(
  input  logic            g_clk,
  input  logic            g_resetn,            // Sync, active low

  input  logic            i_valid,             // Issue strobe
  input  logic            i_flush,             // Cancels this cycle's issue
  input  alu_op_e         i_op,
  input  share_pair_t     i_rs1,
  input  logic [XLEN-1:0] i_z_mask,            // New mask for mask/remask

  input  share_pair_t     i_not,
  input  share_pair_t     i_xor,
  input  share_pair_t     i_and,
  input  share_pair_t     i_ior,
  input  share_pair_t     i_shr,

  output share_pair_t     o_rd,
  output logic            o_ready              // One cycle after issue
);

  // --------------------
  // Mask and remask
  // --------------------
  share_pair_t msk;
  logic        is_remask;

  assign is_remask = (i_op == OP_REMASK);
  assign msk.s0    = i_z_mask ^ i_rs1.s0;
  assign msk.s1    = i_z_mask ^ ({XLEN{is_remask}} & i_rs1.s1);  // Mask keeps s1 = z

  // --------------------
  // Select, one share at a time
  // --------------------
  share_pair_t sel;

  always_comb begin
    case (i_op)
      OP_NOT:                    sel = i_not;
      OP_XOR:                    sel = i_xor;
      OP_AND:                    sel = i_and;
      OP_IOR:                    sel = i_ior;
      OP_SRLI, OP_SLLI, OP_RORI: sel = i_shr;
      OP_MASK, OP_REMASK:        sel = msk;
      default:                   sel = '0;     // Unused codes give zero shares
    endcase
  end

  // --------------------
  // Share register and ready
  // --------------------
  logic        issue;
  share_pair_t rd_q;
  logic        ready_q;

  assign issue = i_valid & ~i_flush;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      rd_q    <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= issue;                        // Single pulse per issue
      if (issue) begin
        rd_q <= sel;                           // Holds until next issue
      end
    end
  end

  assign o_rd    = rd_q;
  assign o_ready = ready_q;

endmodule

// File: src/masked_alu.sv
// --------------------
// Two-share Boolean masked ALU slice
// All randomness comes in on i_rand, fresh every issue
// Fixed one-cycle latency, consumer must take o_rd on o_ready
// --------------------

module masked_alu
  import masked_alu_pkg::*;
(
  input  logic        g_clk,
  input  logic        g_resetn,                // Sync, active low

  input  logic        i_valid,                 // Issue when high and no flush
  input  logic        i_flush,                 // Drop the op in this cycle
  input  alu_req_t    i_req,                   // Op and operand shares
  input  rand_t       i_rand,                  // Fresh randomness

  output logic        o_ready,                 // Result pulse
  output share_pair_t o_rd                     // Result shares
);

  // --------------------
  // Unit results
  // --------------------
  share_pair_t r_not;
  share_pair_t r_xor;
  share_pair_t r_and;
  share_pair_t r_ior;
  share_pair_t r_shr;

  masked_logic logic_ins (
    .i_a     (i_req.rs1),
    .i_b     (i_req.rs2),
    .i_z_and (i_rand.z_and),
    .i_z_xor (i_rand.z_xor),
    .o_not   (r_not),
    .o_xor   (r_xor),
    .o_and   (r_and),
    .o_ior   (r_ior)
  );

  masked_shift shift_ins (
    .i_op    (i_req.op),
    .i_shamt (i_req.rs2.s0[SHAMT_W-1:0]),      // Shamt from share 0 only
    .i_a     (i_req.rs1),
    .i_pad   (i_rand.z_pad),
    .o_shr   (r_shr)
  );

  // Select and register, also closes the DOM gadget
  result_stage result_ins (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_flush  (i_flush),
    .i_op     (i_req.op),
    .i_rs1    (i_req.rs1),
    .i_z_mask (i_rand.z_mask),
    .i_not    (r_not),
    .i_xor    (r_xor),
    .i_and    (r_and),
    .i_ior    (r_ior),
    .i_shr    (r_shr),
    .o_rd     (o_rd),
    .o_ready  (o_ready)
  );

endmodule

// File: tests/masked_alu_assertions.sv
// --------------------
// Timing and reset properties for masked_alu, attached by bind
// Assumes a free-running g_clk and synchronous reset
// --------------------

module masked_alu_assertions
  import masked_alu_pkg::*;
(
  input logic        g_clk,
  input logic        g_resetn,
  input logic        i_valid,
  input logic        i_flush,
  input logic        o_ready,
  input share_pair_t o_rd
);

  logic issue;

  assign issue = i_valid & ~i_flush;           // Same rule as the DUT

  // Every issue gives a pulse on the next edge
  ready_after_issue: assert property (
    @(posedge g_clk) disable iff (!g_resetn) issue |=> o_ready
  ) else $error("o_ready missing one cycle after issue");

  // No pulse unless the cycle before issued
  no_ready_without_issue: assert property (
    @(posedge g_clk) disable iff (!g_resetn) !issue |=> !o_ready
  ) else $error("o_ready high without an issue the cycle before");

  // Sync reset clears the outputs on the following edge
  reset_clears_outputs: assert property (
    @(posedge g_clk) !g_resetn |=> (!o_ready && o_rd == '0)
  ) else $error("o_ready or o_rd not zero under reset");

endmodule

bind masked_alu masked_alu_assertions assertions_ins (
  .g_clk    (g_clk),
  .g_resetn (g_resetn),
  .i_valid  (i_valid),
  .i_flush  (i_flush),
  .o_ready  (o_ready),
  .o_rd     (o_rd)
);

// File: tests/tb_masked_alu.sv
// --------------------
// Random stimulus for masked_alu checked on the unmasked value
// One result expected per issue, one cycle later, in order
// Shamt comes from rs2.s0 only and not from the unmasked rs2
// --------------------

module tb_masked_alu
  import masked_alu_pkg::*;
();

  localparam int CLK_PERIOD    = 40;
  localparam int HOLD          = 2;            // Drive delay after the edge
  localparam int DRAIN_TIMEOUT = 100;          // Cycles to wait for pulses

  // Expected result for one issued op
  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] value;                        // Unmasked result
    logic        chk_s1;                       // Mask op where s1 must equal z_mask
    logic [31:0] s1;
    logic [31:0] due;                          // Cycle the pulse should show
  } exp_t;

  logic        g_clk;
  logic        g_resetn;
  logic        i_valid;
  logic        i_flush;
  alu_req_t    i_req;
  rand_t       i_rand;
  logic        o_ready;
  share_pair_t o_rd;

  integer seed;
  int     cycle_count = 0;
  int     checks      = 0;
  int     errors      = 0;
  exp_t   exp_q[$];                            // Pending results in issue order

  masked_alu i_dut (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_valid  (i_valid),
    .i_flush  (i_flush),
    .i_req    (i_req),
    .i_rand   (i_rand),
    .o_ready  (o_ready),
    .o_rd     (o_rd)
  );

  initial begin
    g_clk = 1'b0;
    forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
  end

  always @(posedge g_clk) cycle_count <= cycle_count + 1;

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] ref_result(
    input alu_op_e     op,
    input logic [31:0] a,                      // rs1.s0 ^ rs1.s1
    input logic [31:0] b,                      // rs2.s0 ^ rs2.s1
    input logic [4:0]  sh,
    input logic [31:0] a_s0                    // Mask takes share 0 as plain
  );
    case (op)
      OP_NOT:    return ~a;
      OP_XOR:    return a ^ b;
      OP_AND:    return a & b;
      OP_IOR:    return a | b;
      OP_SRLI:   return a >> sh;
      OP_SLLI:   return a << sh;
      OP_RORI:   return (a >> sh) | (a << (32 - sh));   // sh = 0 leaves a
      OP_MASK:   return a_s0;
      OP_REMASK: return a;
      default:   return 32'h0;
    endcase
  endfunction

  // --------------------
  // Compare on each ready pulse
  // --------------------
  always @(negedge g_clk) begin
    exp_t e;
    if (g_resetn && o_ready) begin
      assert (exp_q.size() != 0)
      else begin
        $display("Error: ready pulse at cycle %0d with no operation pending", cycle_count);
        errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        checks++;
        assert ((o_rd.s0 ^ o_rd.s1) == e.value)
        else begin
          $display("Fail op %0d: o_rd unmasked %h expected %h", e.op, o_rd.s0 ^ o_rd.s1,
                   e.value);
          errors++;
        end
        assert (cycle_count == e.due)
        else begin
          $display("Error: result for op %0d came at cycle %0d instead of %0d", e.op,
                   cycle_count, e.due);
          errors++;
        end
        if (e.chk_s1) begin
          checks++;
          assert (o_rd.s1 == e.s1)
          else begin
            $display("Fail o_rd.s1 %h expected z_mask %h", o_rd.s1, e.s1);
            errors++;
          end
        end
      end
    end
  end

  // --------------------
  // Drive tasks
  // --------------------
  task automatic idle();
    @(posedge g_clk);
    #HOLD;
    i_valid = 1'b0;
    i_flush = 1'b0;
  endtask

  // Random shares and randomness with shamt forced when sh >= 0
  task automatic issue_op(input alu_op_e op, input int sh);
    alu_req_t req;
    rand_t    rnd;
    exp_t     e;
    req.op     = op;
    req.rs1.s0 = $random(seed);
    req.rs1.s1 = $random(seed);
    req.rs2.s0 = $random(seed);
    req.rs2.s1 = $random(seed);
    rnd.z_and  = $random(seed);
    rnd.z_xor  = $random(seed);
    rnd.z_pad  = $random(seed);
    rnd.z_mask = $random(seed);
    if (sh >= 0) req.rs2.s0[4:0] = sh[4:0];
    @(posedge g_clk);
    #HOLD;
    i_valid = 1'b1;
    i_flush = 1'b0;
    i_req   = req;
    i_rand  = rnd;
    e.op     = op;
    e.value  = ref_result(op, req.rs1.s0 ^ req.rs1.s1, req.rs2.s0 ^ req.rs2.s1,
                          req.rs2.s0[4:0], req.rs1.s0);
    e.chk_s1 = (op == OP_MASK);
    e.s1     = rnd.z_mask;
    e.due    = cycle_count + 1;                // Sampled on the next edge
    exp_q.push_back(e);
  endtask

  // Valid with flush so nothing is queued
  task automatic issue_flush();
    alu_req_t req;
    req.op     = alu_op_e'($unsigned($random(seed)) % 9);
    req.rs1.s0 = $random(seed);
    req.rs1.s1 = $random(seed);
    req.rs2.s0 = $random(seed);
    req.rs2.s1 = $random(seed);
    @(posedge g_clk);
    #HOLD;
    i_valid = 1'b1;
    i_flush = 1'b1;
    i_req   = req;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
      @(posedge g_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Error: timed out waiting for ready, %0d results still pending",
               exp_q.size());
      $display("sim failed");
      $finish;
    end
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("test %-10s checks %0d errors %0d", name, checks - c0, errors - e0);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int          c0;
    int          e0;
    int          k;
    share_pair_t held;
    seed     = 46797;
    g_resetn = 1'b0;
    i_valid  = 1'b0;
    i_flush  = 1'b0;
    i_req    = '0;
    i_rand   = '0;
    repeat (5) @(posedge g_clk);
    #HOLD g_resetn = 1'b1;

    // Outputs cleared by reset
    c0 = checks;
    e0 = errors;
    @(negedge g_clk);
    checks++;
    assert (!o_ready && o_rd == '0)
    else begin
      $display("Fail after reset: o_ready %h o_rd %h", o_ready, o_rd);
      errors++;
    end
    report_test("reset", c0, e0);

    // Boolean ops, one at a time
    c0 = checks;
    e0 = errors;
    for (k = 0; k < 40; k++) begin
      issue_op(alu_op_e'(k % 4), -1);          // NOT, XOR, AND, IOR in turn
      idle();
      drain();
    end
    report_test("logic", c0, e0);

    // Every shift amount for each shifter op
    c0 = checks;
    e0 = errors;
    for (k = 0; k < 32; k++) begin
      issue_op(OP_SRLI, k);
      issue_op(OP_SLLI, k);
      issue_op(OP_RORI, k);
      idle();
      drain();
    end
    report_test("shift", c0, e0);

    c0 = checks;
    e0 = errors;
    for (k = 0; k < 20; k++) begin
      issue_op(OP_MASK, -1);
      issue_op(OP_REMASK, -1);
    end
    idle();
    drain();
    report_test("mask", c0, e0);

    // Back to back over all op codes
    c0 = checks;
    e0 = errors;
    for (k = 0; k < 30; k++) begin
      issue_op(alu_op_e'($unsigned($random(seed)) % 9), -1);
    end
    idle();
    drain();
    report_test("stream", c0, e0);

    // Flushed issue gives no pulse and o_rd holds
    c0 = checks;
    e0 = errors;
    issue_op(OP_XOR, -1);
    idle();
    drain();
    held = o_rd;
    issue_flush();
    idle();
    repeat (3) begin
      @(negedge g_clk);
      checks++;
      assert (!o_ready && o_rd == held)
      else begin
        $display("Fail after flush: o_ready %h o_rd %h expected %h", o_ready, o_rd, held);
        errors++;
      end
    end
    issue_flush();
    issue_op(OP_AND, -1);                      // Only this one may pulse
    idle();
    drain();
    report_test("flush", c0, e0);

    $display("total checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
src/masked_alu_pkg.sv
src/masked_logic.sv
src/masked_shift.sv
src/result_stage.sv
src/masked_alu.sv
tests/masked_alu_assertions.sv
tests/tb_masked_alu.sv
